// File: src/scalar_macros.svh
// ---------------------------------------------------------------------------
// Scalar core parameters
// ---------------------------------------------------------------------------

`ifndef SCALAR_MACROS_SVH
`define SCALAR_MACROS_SVH

// Instruction word is opcode, D, A, B from the top bit down
`define SC_WORD_WIDTH           16
`define SC_OPCODE_WIDTH         4
`define SC_OPERAND_WIDTH        7
`define SC_D_OPERAND_WIDTH      8
`define SC_INSTR_WIDTH          26

// Data memories and the I/O window at the top of each
`define SC_MEM_DEPTH            128
`define SC_IO_BASE_ADDR         126
`define SC_IO_PORT_COUNT        2

// Threads, one per pipeline stage
`define SC_THREAD_COUNT         4
`define SC_THREAD_WIDTH         2
`define SC_THREAD_WINDOW        32
`define SC_PC_WIDTH             6
`define SC_IMEM_DEPTH           64
`define SC_THREAD_PROGRAM_SIZE  16

`endif

// File: src/scalar_pkg.sv
// ---------------------------------------------------------------------------
// Scalar core types
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

package scalar_pkg;

    typedef logic [`SC_WORD_WIDTH-1:0]    word_t;
    typedef logic [`SC_OPERAND_WIDTH-1:0] addr_t;

    // One bit per I/O port of a side
    typedef logic [`SC_IO_PORT_COUNT-1:0] io_sel_t;

    typedef enum logic [`SC_OPCODE_WIDTH-1:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        AND    = 4'd3,
        OR     = 4'd4,
        XOR    = 4'd5,
        PASS_A = 4'd6
    } opcode_e;

    // Opcodes outside this set behave as NOP and write nothing
    function automatic logic is_alu_op(input opcode_e op);
        return op inside {ADD, SUB, AND, OR, XOR, PASS_A};
    endfunction

endpackage

// File: src/issue_if.sv
// ---------------------------------------------------------------------------
// Translated instruction bus
// ---------------------------------------------------------------------------

interface issue_if;

    scalar_pkg::opcode_e opcode;
    scalar_pkg::addr_t   a_addr;
    logic                a_io;
    scalar_pkg::addr_t   b_addr;
    logic                b_io;
    scalar_pkg::addr_t   d_addr;
    logic                d_side;
    logic                d_io;

    modport translator (output opcode, a_addr, a_io, b_addr, b_io, d_addr, d_side, d_io);
    modport datapath   (input  opcode, a_addr, a_io, b_addr, b_io, d_addr, d_side, d_io);

endinterface

// File: src/thread_scheduler.sv
// ---------------------------------------------------------------------------
// Thread counter and program counters
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module thread_scheduler (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        cancel,
    output logic [`SC_THREAD_WIDTH-1:0] thread,
    output logic [`SC_PC_WIDTH-1:0]     pc
);

    localparam int TW = `SC_THREAD_WIDTH;
    localparam int PW = `SC_PC_WIDTH;
    localparam int OW = PW - TW;

    logic [TW-1:0] thread_q;
    logic [TW-1:0] thread_next;
    logic [TW-1:0] exec_thread;
    // Fill flags for the stages between fetch and the cancel decision
    logic [1:0]    primed;
    logic [PW-1:0] pcs [`SC_THREAD_COUNT];

    assign thread_next = thread_q + 1'b1;
    // Thread whose instruction is deciding cancel this cycle
    assign exec_thread = thread_q - TW'(2);
    assign thread      = thread_q;
    assign pc          = pcs[thread_q];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_q <= '0;
            primed   <= '0;
            for (int t = 0; t < `SC_THREAD_COUNT; t++) begin
                pcs[t] <= PW'(t * `SC_THREAD_PROGRAM_SIZE);
            end
        end else begin
            thread_q <= thread_next;
            primed   <= {primed[0], 1'b1};
            // Wrap inside the thread's own program region
            if (primed[1] && !cancel) begin
                pcs[exec_thread] <= {pcs[exec_thread][PW-1:OW],
                                     pcs[exec_thread][OW-1:0] + 1'b1};
            end
        end
    end

    thread_round_robin: assert property (@(posedge clock) disable iff (!rst_n)
        1'b1 |=> thread_q == TW'(($past(thread_q) + 1) % `SC_THREAD_COUNT));

endmodule

// File: src/instr_memory.sv
// ---------------------------------------------------------------------------
// Instruction memory
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module instr_memory (
    input  logic                       clock,
    input  logic                       prog_wren,
    input  logic [`SC_PC_WIDTH-1:0]    prog_addr,
    input  logic [`SC_INSTR_WIDTH-1:0] prog_data,
    input  logic [`SC_PC_WIDTH-1:0]    pc,
    output logic [`SC_INSTR_WIDTH-1:0] instr
);

    logic [`SC_INSTR_WIDTH-1:0] mem [`SC_IMEM_DEPTH];

    // Program load port
    always_ff @(posedge clock) begin
        if (prog_wren) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch, one cycle of latency
    always_ff @(posedge clock) begin
        instr <= mem[pc];
    end

endmodule

// File: src/address_translator.sv
// ---------------------------------------------------------------------------
// Operand decode and address translation
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module address_translator (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [`SC_INSTR_WIDTH-1:0]  instr,
    input  logic [`SC_THREAD_WIDTH-1:0] thread,
    issue_if.translator                 issue
);

    localparam int AW  = `SC_OPERAND_WIDTH;
    localparam int DW  = `SC_D_OPERAND_WIDTH;
    localparam int OPW = `SC_OPCODE_WIDTH;

    scalar_pkg::opcode_e          opcode;
    logic [DW-1:0]                d_raw;
    scalar_pkg::addr_t            a_raw;
    scalar_pkg::addr_t            b_raw;
    logic [`SC_THREAD_WIDTH-1:0]  thread_d;
    logic [AW-1:0]                offset;
    // Low while the instruction register still holds a word read during reset
    logic                         fetch_valid;

    function automatic logic is_io(input scalar_pkg::addr_t addr);
        return addr >= AW'(`SC_IO_BASE_ADDR);
    endfunction

    // I/O addresses bypass the thread offset
    function automatic scalar_pkg::addr_t translate(input scalar_pkg::addr_t addr,
                                                    input logic [AW-1:0] ofs);
        return is_io(addr) ? addr : addr + ofs;
    endfunction

    assign opcode                = scalar_pkg::opcode_e'(instr[`SC_INSTR_WIDTH-1 -: OPW]);
    assign {d_raw, a_raw, b_raw} = instr[DW+2*AW-1:0];
    assign offset                = AW'(thread_d * `SC_THREAD_WINDOW);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_d     <= '0;
            fetch_valid  <= 1'b0;
            issue.opcode <= scalar_pkg::NOP;
            issue.a_io   <= 1'b0;
            issue.b_io   <= 1'b0;
            issue.d_io   <= 1'b0;
        end else begin
            thread_d     <= thread;
            fetch_valid  <= 1'b1;
            issue.opcode <= fetch_valid ? opcode : scalar_pkg::NOP;
            issue.a_io   <= fetch_valid && is_io(a_raw);
            issue.b_io   <= fetch_valid && is_io(b_raw);
            issue.d_io   <= fetch_valid && is_io(d_raw[AW-1:0])
                            && scalar_pkg::is_alu_op(opcode);
        end
    end

    always_ff @(posedge clock) begin
        issue.a_addr <= translate(a_raw, offset);
        issue.b_addr <= translate(b_raw, offset);
        issue.d_addr <= translate(d_raw[AW-1:0], offset);
        issue.d_side <= d_raw[DW-1];
    end

endmodule

// File: src/io_port_bank.sv
// ---------------------------------------------------------------------------
// I/O ports of one side
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module io_port_bank (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        rd_sel,
    input  logic [$clog2(`SC_IO_PORT_COUNT)-1:0]        rd_addr,
    input  logic                                        wr_sel,
    input  logic [$clog2(`SC_IO_PORT_COUNT)-1:0]        wr_addr,
    input  logic                                        cancel,
    input  scalar_pkg::io_sel_t                         in_ef,
    output scalar_pkg::io_sel_t                         rden,
    input  logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] in,
    input  scalar_pkg::io_sel_t                         out_ef,
    output scalar_pkg::io_sel_t                         wren,
    output logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] out,
    output scalar_pkg::word_t                           rd_data,
    output logic                                        ready,
    input  scalar_pkg::word_t                           wr_data
);

    localparam int W = `SC_WORD_WIDTH;

    assign rd_data = in[rd_addr*W +: W];

    // Not ready if the addressed input is empty or the addressed output is full
    assign ready = (!rd_sel || in_ef[rd_addr]) && (!wr_sel || out_ef[wr_addr]);

    always_comb begin
        rden = '0;
        if (rd_sel && !cancel) begin
            rden[rd_addr] = 1'b1;
        end
    end

    // Write strobe lands one cycle after the decision
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wren <= '0;
        end else begin
            wren <= '0;
            if (wr_sel && !cancel) begin
                wren[wr_addr] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `SC_IO_PORT_COUNT; p++) begin
            out[p*W +: W] = wren[p] ? wr_data : '0;
        end
    end

    rden_needs_data: assert property (@(posedge clock) disable iff (!rst_n)
        (rden & ~in_ef) == '0);

endmodule

// File: src/datapath.sv
// ---------------------------------------------------------------------------
// Data memories, ALU and write-back
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module datapath (
    input  logic                                        clock,
    input  logic                                        rst_n,
    issue_if.datapath                                   issue,
    input  scalar_pkg::io_sel_t                         a_io_in_ef,
    output scalar_pkg::io_sel_t                         a_io_rden,
    input  logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] a_io_in,
    input  scalar_pkg::io_sel_t                         a_io_out_ef,
    output scalar_pkg::io_sel_t                         a_io_wren,
    output logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] a_io_out,
    input  scalar_pkg::io_sel_t                         b_io_in_ef,
    output scalar_pkg::io_sel_t                         b_io_rden,
    input  logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] b_io_in,
    input  scalar_pkg::io_sel_t                         b_io_out_ef,
    output scalar_pkg::io_sel_t                         b_io_wren,
    output logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] b_io_out,
    output logic                                        cancel
);

    localparam int AW = `SC_OPERAND_WIDTH;
    localparam int PW = $clog2(`SC_IO_PORT_COUNT);

    scalar_pkg::word_t   mem_a [`SC_MEM_DEPTH];
    scalar_pkg::word_t   mem_b [`SC_MEM_DEPTH];
    scalar_pkg::word_t   a_io_data;
    scalar_pkg::word_t   b_io_data;
    scalar_pkg::word_t   a_val;
    scalar_pkg::word_t   b_val;
    logic                a_ready;
    logic                b_ready;
    logic [PW-1:0]       a_port;
    logic [PW-1:0]       b_port;
    logic [PW-1:0]       d_port;

    // Write-back stage
    scalar_pkg::opcode_e op_q;
    scalar_pkg::word_t   a_q;
    scalar_pkg::word_t   b_q;
    scalar_pkg::addr_t   d_addr_q;
    logic                d_side_q;
    logic                mem_wr_q;
    scalar_pkg::word_t   result;

    assign a_port = PW'(issue.a_addr - AW'(`SC_IO_BASE_ADDR));
    assign b_port = PW'(issue.b_addr - AW'(`SC_IO_BASE_ADDR));
    assign d_port = PW'(issue.d_addr - AW'(`SC_IO_BASE_ADDR));

    io_port_bank a_bank (
        .clock, .rst_n, .cancel,
        .rd_sel (issue.a_io),               .rd_addr (a_port),
        .wr_sel (issue.d_io && !issue.d_side), .wr_addr (d_port),
        .in_ef  (a_io_in_ef),  .rden (a_io_rden), .in  (a_io_in),
        .out_ef (a_io_out_ef), .wren (a_io_wren), .out (a_io_out),
        .rd_data (a_io_data), .ready (a_ready), .wr_data (result)
    );

    io_port_bank b_bank (
        .clock, .rst_n, .cancel,
        .rd_sel (issue.b_io),               .rd_addr (b_port),
        .wr_sel (issue.d_io && issue.d_side), .wr_addr (d_port),
        .in_ef  (b_io_in_ef),  .rden (b_io_rden), .in  (b_io_in),
        .out_ef (b_io_out_ef), .wren (b_io_wren), .out (b_io_out),
        .rd_data (b_io_data), .ready (b_ready), .wr_data (result)
    );

    assign cancel = !(a_ready && b_ready);
    assign a_val  = issue.a_io ? a_io_data : mem_a[issue.a_addr];
    assign b_val  = issue.b_io ? b_io_data : mem_b[issue.b_addr];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mem_wr_q <= 1'b0;
        end else begin
            mem_wr_q <= scalar_pkg::is_alu_op(issue.opcode) && !issue.d_io && !cancel;
        end
    end

    always_ff @(posedge clock) begin
        op_q     <= issue.opcode;
        a_q      <= a_val;
        b_q      <= b_val;
        d_addr_q <= issue.d_addr;
        d_side_q <= issue.d_side;
    end

    // ---------------------------------------------------------------------
    // ALU and memory write-back

    always_comb begin
        case (op_q)
            scalar_pkg::ADD:    result = a_q + b_q;
            scalar_pkg::SUB:    result = a_q - b_q;
            scalar_pkg::AND:    result = a_q & b_q;
            scalar_pkg::OR:     result = a_q | b_q;
            scalar_pkg::XOR:    result = a_q ^ b_q;
            scalar_pkg::PASS_A: result = a_q;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (mem_wr_q && !d_side_q) begin
            mem_a[d_addr_q] <= result;
        end
        if (mem_wr_q && d_side_q) begin
            mem_b[d_addr_q] <= result;
        end
    end

    cancel_blocks_write: assert property (@(posedge clock) disable iff (!rst_n)
        cancel |=> !mem_wr_q && a_io_wren == '0 && b_io_wren == '0);

endmodule

// File: src/scalar_core.sv
// ---------------------------------------------------------------------------
// Four-thread scalar barrel processor
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module scalar_core (
    input  logic                                        clock,
    input  logic                                        rst_n,

    // Program load
    input  logic                                        prog_wren,
    input  logic [`SC_PC_WIDTH-1:0]                     prog_addr,
    input  logic [`SC_INSTR_WIDTH-1:0]                  prog_data,

    // Side A ports
    input  logic [`SC_IO_PORT_COUNT-1:0]                a_io_in_ef,
    output logic [`SC_IO_PORT_COUNT-1:0]                a_io_rden,
    input  logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] a_io_in,
    input  logic [`SC_IO_PORT_COUNT-1:0]                a_io_out_ef,
    output logic [`SC_IO_PORT_COUNT-1:0]                a_io_wren,
    output logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] a_io_out,

    // Side B ports
    input  logic [`SC_IO_PORT_COUNT-1:0]                b_io_in_ef,
    output logic [`SC_IO_PORT_COUNT-1:0]                b_io_rden,
    input  logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] b_io_in,
    input  logic [`SC_IO_PORT_COUNT-1:0]                b_io_out_ef,
    output logic [`SC_IO_PORT_COUNT-1:0]                b_io_wren,
    output logic [`SC_IO_PORT_COUNT*`SC_WORD_WIDTH-1:0] b_io_out
);

    logic [`SC_THREAD_WIDTH-1:0] thread;
    logic [`SC_PC_WIDTH-1:0]     pc;
    logic [`SC_INSTR_WIDTH-1:0]  instr;
    logic                        cancel;

    issue_if issue_bus ();

    // ---------------------------------------------------------------------
    // Fetch and translate

    thread_scheduler scheduler (
        .clock  (clock),
        .rst_n  (rst_n),
        .cancel (cancel),
        .thread (thread),
        .pc     (pc)
    );

    instr_memory imem (
        .clock     (clock),
        .prog_wren (prog_wren),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    address_translator translator (
        .clock  (clock),
        .rst_n  (rst_n),
        .instr  (instr),
        .thread (thread),
        .issue  (issue_bus)
    );

    // ---------------------------------------------------------------------
    // Execute

    datapath dp (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue       (issue_bus),
        .a_io_in_ef  (a_io_in_ef),
        .a_io_rden   (a_io_rden),
        .a_io_in     (a_io_in),
        .a_io_out_ef (a_io_out_ef),
        .a_io_wren   (a_io_wren),
        .a_io_out    (a_io_out),
        .b_io_in_ef  (b_io_in_ef),
        .b_io_rden   (b_io_rden),
        .b_io_in     (b_io_in),
        .b_io_out_ef (b_io_out_ef),
        .b_io_wren   (b_io_wren),
        .b_io_out    (b_io_out),
        .cancel      (cancel)
    );

endmodule

// File: verification/scalar_core_tests.svh
// ---------------------------------------------------------------------------
// Program encoder and directed tests
// ---------------------------------------------------------------------------

`ifndef SCALAR_CORE_TESTS_SVH
`define SCALAR_CORE_TESTS_SVH

// Logical I/O addresses and D fields
localparam logic [6:0] IO0   = 7'd126;
localparam logic [6:0] IO1   = 7'd127;
localparam logic [7:0] D_A0  = 8'h7e;
localparam logic [7:0] D_A1  = 8'h7f;
localparam logic [7:0] D_B0  = 8'hfe;
localparam logic [7:0] D_B1  = 8'hff;

function automatic logic [25:0] encode(input logic [3:0] op, input logic [7:0] d,
                                       input logic [6:0] a, input logic [6:0] b);
    return {op, d, a, b};
endfunction

function automatic logic [15:0] alu_expect(input logic [3:0] op, input logic [15:0] a,
                                           input logic [15:0] b);
    case (op)
        4'd1:    return a + b;
        4'd2:    return a - b;
        4'd3:    return a & b;
        4'd4:    return a | b;
        4'd5:    return a ^ b;
        default: return a;
    endcase
endfunction

task automatic clear_program();
    for (int i = 0; i < `SC_IMEM_DEPTH; i++) begin
        prog_words[i] = encode(4'd0, 8'h0, 7'h0, 7'h0);
    end
endtask

// Program is written while the core is held in reset
task automatic reset_and_load();
    @(posedge clock);
    #DRIVE_DELAY;
    rst_n      = 1'b0;
    out_ef_set = '1;
    rden_count = 0;
    wren_count = 0;
    for (int i = 0; i < PORTS; i++) begin
        in_q[i].delete();
        out_q[i].delete();
    end
    for (int i = 0; i < `SC_IMEM_DEPTH; i++) begin
        prog_wren = 1'b1;
        prog_addr = 6'(i);
        prog_data = prog_words[i];
        @(posedge clock);
        #DRIVE_DELAY;
    end
    prog_wren = 1'b0;
    repeat (5) @(posedge clock);
    #DRIVE_DELAY;
    rst_n = 1'b1;
endtask

task automatic wait_for_words(input int idx, input int count);
    while (out_q[idx].size() < count) begin
        @(posedge clock);
    end
endtask

task automatic test_pass_through();
    logic [15:0] sent [$];
    logic [15:0] w;
    clear_program();
    for (int i = 0; i < 16; i++) begin
        prog_words[i] = encode(4'd6, D_A0, IO0, 7'd0);
    end
    reset_and_load();
    for (int i = 0; i < 8; i++) begin
        w = 16'($urandom());
        sent.push_back(w);
        in_q[0].push_back(w);
    end
    wait_for_words(0, 8);
    repeat (20) @(posedge clock);
    check("a_io_out[0] count", 32'(out_q[0].size()), 32'd8);
    for (int i = 0; i < 8; i++) begin
        check("a_io_out[0]", 32'(out_q[0][i]), 32'(sent[i]));
    end
endtask

task automatic test_alu();
    logic [3:0]  ops [5];
    logic [15:0] a_words [5];
    logic [15:0] b_words [5];
    ops = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5};
    clear_program();
    for (int i = 0; i < 5; i++) begin
        prog_words[16 + i] = encode(ops[i], D_B1, IO1, IO0);
    end
    reset_and_load();
    for (int i = 0; i < 5; i++) begin
        a_words[i] = 16'($urandom());
        b_words[i] = 16'($urandom());
        in_q[1].push_back(a_words[i]);
        in_q[2].push_back(b_words[i]);
    end
    wait_for_words(3, 5);
    for (int i = 0; i < 5; i++) begin
        check("b_io_out[1]", 32'(out_q[3][i]),
              32'(alu_expect(ops[i], a_words[i], b_words[i])));
    end
endtask

task automatic test_private_memory();
    logic [15:0] w0;
    logic [15:0] w2;
    clear_program();
    prog_words[0]  = encode(4'd6, 8'h05, IO0, 7'd0);
    prog_words[1]  = encode(4'd6, D_A0, 7'd5, 7'd0);
    prog_words[32] = encode(4'd6, 8'h05, IO1, 7'd0);
    prog_words[33] = encode(4'd6, D_A1, 7'd5, 7'd0);
    reset_and_load();
    w0 = 16'($urandom());
    w2 = 16'($urandom());
    in_q[0].push_back(w0);
    in_q[1].push_back(w2);
    wait_for_words(0, 1);
    wait_for_words(1, 1);
    repeat (40) @(posedge clock);
    check("a_io_out[0] count", 32'(out_q[0].size()), 32'd1);
    check("a_io_out[1] count", 32'(out_q[1].size()), 32'd1);
    check("a_io_out[0] thread 0", 32'(out_q[0][0]), 32'(w0));
    check("a_io_out[1] thread 2", 32'(out_q[1][0]), 32'(w2));
endtask

task automatic test_back_pressure();
    logic [15:0] sent [$];
    logic [15:0] w;
    clear_program();
    for (int i = 48; i < 64; i++) begin
        prog_words[i] = encode(4'd6, D_B0, IO1, 7'd0);
    end
    reset_and_load();
    // B output 0 full while input words wait
    out_ef_set = 4'b1011;
    for (int i = 0; i < 6; i++) begin
        w = 16'($urandom());
        sent.push_back(w);
        in_q[1].push_back(w);
    end
    repeat (40) @(posedge clock);
    check("rden count while full", 32'(rden_count), 32'd0);
    check("wren count while full", 32'(wren_count), 32'd0);
    out_ef_set = 4'b1111;
    wait_for_words(2, 6);
    // Input empty now
    repeat (40) @(posedge clock);
    check("rden count while empty", 32'(rden_count), 32'd6);
    check("wren count while empty", 32'(wren_count), 32'd6);
    for (int i = 0; i < 3; i++) begin
        w = 16'($urandom());
        sent.push_back(w);
        in_q[1].push_back(w);
    end
    wait_for_words(2, 9);
    repeat (20) @(posedge clock);
    check("b_io_out[0] count", 32'(out_q[2].size()), 32'd9);
    for (int i = 0; i < 9; i++) begin
        check("b_io_out[0]", 32'(out_q[2][i]), 32'(sent[i]));
    end
endtask

task automatic test_timing();
    logic [15:0] w;
    clear_program();
    prog_words[0] = encode(4'd6, D_A0, IO0, 7'd0);
    reset_and_load();
    @(negedge clock);
    check("rden after reset", 32'(rden_all), 32'd0);
    check("wren after reset", 32'(wren_all), 32'd0);
    w = 16'($urandom());
    in_q[0].push_back(w);
    wait_for_words(0, 1);
    check("a_io_out[0]", 32'(out_q[0][0]), 32'(w));
    check("a_io_wren[0] cycle", 32'(wren_cycle[0]), 32'(rden_cycle[0] + 1));
endtask

`endif

// File: verification/scalar_core_tb.sv
// ---------------------------------------------------------------------------
// Scalar core testbench
// ---------------------------------------------------------------------------

`include "scalar_macros.svh"

module scalar_core_tb;

    localparam int PERIOD      = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int PORTS       = 4;
    // Estimated cycles of load, reset, stimulus and drain for each test
    localparam int TEST_LENGTH_SUM = 300 + 300 + 250 + 450 + 250;
    localparam int WATCHDOG_TIME   = TEST_LENGTH_SUM * `SC_THREAD_COUNT * PERIOD;

    logic                       clock;
    logic                       rst_n;
    logic                       prog_wren;
    logic [`SC_PC_WIDTH-1:0]    prog_addr;
    logic [`SC_INSTR_WIDTH-1:0] prog_data;

    // Port index is side * 2 + port, side A first
    logic [PORTS-1:0]           in_ef_all;
    logic [PORTS-1:0]           out_ef_all;
    logic [PORTS-1:0]           out_ef_set;
    logic [PORTS-1:0]           rden_all;
    logic [PORTS-1:0]           wren_all;
    logic [15:0]                in_word [PORTS];
    logic [31:0]                a_out;
    logic [31:0]                b_out;
    logic [15:0]                out_word [PORTS];

    logic [15:0]                in_q  [PORTS][$];
    logic [15:0]                out_q [PORTS][$];
    logic [`SC_INSTR_WIDTH-1:0] prog_words [`SC_IMEM_DEPTH];
    int                         rden_count;
    int                         wren_count;
    int                         rden_cycle [PORTS];
    int                         wren_cycle [PORTS];
    int                         cycle;
    int                         failures;

    scalar_core dut_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .prog_wren   (prog_wren),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .a_io_in_ef  (in_ef_all[1:0]),
        .a_io_rden   (rden_all[1:0]),
        .a_io_in     ({in_word[1], in_word[0]}),
        .a_io_out_ef (out_ef_all[1:0]),
        .a_io_wren   (wren_all[1:0]),
        .a_io_out    (a_out),
        .b_io_in_ef  (in_ef_all[3:2]),
        .b_io_rden   (rden_all[3:2]),
        .b_io_in     ({in_word[3], in_word[2]}),
        .b_io_out_ef (out_ef_all[3:2]),
        .b_io_wren   (wren_all[3:2]),
        .b_io_out    (b_out)
    );

    assign out_word[0] = a_out[15:0];
    assign out_word[1] = a_out[31:16];
    assign out_word[2] = b_out[15:0];
    assign out_word[3] = b_out[31:16];

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Input queues and output room, driven just after the edge
    always @(posedge clock) begin
        #DRIVE_DELAY;
        for (int i = 0; i < PORTS; i++) begin
            in_ef_all[i] = in_q[i].size() != 0;
            in_word[i]   = (in_q[i].size() != 0) ? in_q[i][0] : 16'h0;
        end
        out_ef_all = out_ef_set;
    end

    // Enables are stable mid-cycle
    always @(negedge clock) begin
        if (rst_n) begin
            for (int i = 0; i < PORTS; i++) begin
                if (rden_all[i]) begin
                    void'(in_q[i].pop_front());
                    rden_count++;
                    rden_cycle[i] = cycle;
                end
                if (wren_all[i]) begin
                    out_q[i].push_back(out_word[i]);
                    wren_count++;
                    wren_cycle[i] = cycle;
                end
            end
        end
    end

    task automatic report_failure(input string why);
        failures++;
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    `include "scalar_core_tests.svh"

    initial begin
        #(WATCHDOG_TIME);
        report_failure("Watchdog expired before the tests finished");
    end

    initial begin
        rst_n      = 1'b0;
        prog_wren  = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        in_ef_all  = '0;
        out_ef_all = '0;
        out_ef_set = '0;
        cycle      = 0;
        failures   = 0;
        for (int i = 0; i < PORTS; i++) begin
            in_word[i] = '0;
        end
        void'($urandom(32'hb53c_48a8));

        test_pass_through();
        test_alu();
        test_private_memory();
        test_back_pressure();
        test_timing();

        if (failures == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_failure("Test run ended with recorded failures");
        end
    end

endmodule

// File: scalar_core.f
+incdir+src
+incdir+verification
src/scalar_pkg.sv
src/issue_if.sv
src/thread_scheduler.sv
src/instr_memory.sv
src/address_translator.sv
src/io_port_bank.sv
src/datapath.sv
src/scalar_core.sv
verification/scalar_core_tb.sv

// File: Makefile
SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv verification/*.svh)

.PHONY: run clean

run: obj_dir/Vscalar_core_tb
	./obj_dir/Vscalar_core_tb

obj_dir/Vscalar_core_tb: $(SOURCES) scalar_core.f
	verilator --binary --timing --assert -f scalar_core.f \
		--top-module scalar_core_tb -Mdir obj_dir -o Vscalar_core_tb

clean:
	rm -rf obj_dir
